// File: design/rv_pkg.sv
package rv_pkg;

    // Datapath and register file sizes
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int nregs      = 32;

    // Major opcodes of the supported subset
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_lui    = 7'b0110111;

    // Branch conditions by funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef enum logic [3:0] {
        alu_add,      // Also the value for unknown opcodes
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu
    } alu_op_t;

    typedef enum logic [2:0] {
        s_fetch,
        s_decode,
        s_execute,
        s_memory,
        s_writeback
    } state_t;

    // Wishbone classic master request
    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic            we;
        logic [xlen-1:0] adr;
        logic [xlen-1:0] dat_w;
    } wb_req_t;

    // Decoded control of the instruction in IR
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;  // Operand B from the immediate
        logic    branch;
        logic    jump;
        logic    lui;          // Operand A forced to zero
        logic    mem_to_reg;
        alu_op_t alu_op;
    } ctrl_t;

endpackage

// File: design/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::alu_op_t         op,
    input  logic [2:0]              funct3,
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    output logic [rv_pkg::xlen-1:0] result,
    output logic                    branch_taken
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            rv_pkg::alu_add:  result = a + b;
            rv_pkg::alu_sub:  result = a - b;
            rv_pkg::alu_and:  result = a & b;
            rv_pkg::alu_or:   result = a | b;
            rv_pkg::alu_xor:  result = a ^ b;
            rv_pkg::alu_sll:  result = a << shamt;
            rv_pkg::alu_srl:  result = a >> shamt;
            rv_pkg::alu_sra:  result = $signed(a) >>> shamt;
            rv_pkg::alu_slt:  result = {{(rv_pkg::xlen-1){1'b0}}, lt_signed};
            rv_pkg::alu_sltu: result = {{(rv_pkg::xlen-1){1'b0}}, lt_unsigned};
            default:          result = '0;
        endcase
    end

    // Condition only, the FSM qualifies it with the branch bit
    always_comb begin
        case (funct3)
            rv_pkg::f3_beq:  branch_taken = (a == b);
            rv_pkg::f3_bne:  branch_taken = (a != b);
            rv_pkg::f3_blt:  branch_taken = lt_signed;
            rv_pkg::f3_bge:  branch_taken = !lt_signed;
            rv_pkg::f3_bltu: branch_taken = lt_unsigned;
            rv_pkg::f3_bgeu: branch_taken = !lt_unsigned;
            default:         branch_taken = 1'b0;
        endcase
    end

endmodule

// File: design/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  logic [31:0]             instr,
    output rv_pkg::ctrl_t           ctrl,
    output logic [rv_pkg::xlen-1:0] imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_5;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7_5 = instr[30];

    // Shared by R-type and I-type, alt picks sub or sra
    function automatic rv_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        rv_pkg::alu_op_t sel;
        case (f3)
            3'b000:  sel = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  sel = rv_pkg::alu_sll;
            3'b010:  sel = rv_pkg::alu_slt;
            3'b011:  sel = rv_pkg::alu_sltu;
            3'b100:  sel = rv_pkg::alu_xor;
            3'b101:  sel = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  sel = rv_pkg::alu_or;
            default: sel = rv_pkg::alu_and;
        endcase
        return sel;
    endfunction

    always_comb begin
        ctrl = '0;
        case (opcode)
            rv_pkg::op_reg: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_sel(funct3, funct7_5);
            end
            rv_pkg::op_imm: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_sel(funct3, funct7_5 && funct3 == 3'b101); // No subi
            end
            rv_pkg::op_load: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
            end
            rv_pkg::op_store: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            rv_pkg::op_branch: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = rv_pkg::alu_sub;
            end
            rv_pkg::op_jal: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
            end
            rv_pkg::op_lui: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.lui         = 1'b1;  // 0 + U immediate
            end
            default: ;
        endcase
    end

    always_comb begin
        case (opcode)
            rv_pkg::op_imm, rv_pkg::op_load: imm = {{20{instr[31]}}, instr[31:20]};
            rv_pkg::op_store:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_pkg::op_branch: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            rv_pkg::op_jal: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            rv_pkg::op_lui:    imm = {instr[31:12], 12'b0};
            default:           imm = '0;
        endcase
    end

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2,
    input  logic [rv_pkg::reg_addr_w-1:0] rd,
    input  logic                          we,
    input  logic [rv_pkg::xlen-1:0]       wd,
    output logic [rv_pkg::xlen-1:0]       rd1,
    output logic [rv_pkg::xlen-1:0]       rd2
);

    logic [rv_pkg::xlen-1:0] regs [rv_pkg::nregs];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < rv_pkg::nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin  // x0 stays zero
            regs[rd] <= wd;
        end
    end

    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

endmodule

// File: design/rv_control_fsm.sv
`timescale 1ns/1ps

module rv_control_fsm (
    input  logic          clk,
    input  logic          reset,
    input  rv_pkg::ctrl_t ctrl,
    input  logic          branch_taken,
    input  logic          wb_ack,
    output logic          bus_cyc,
    output logic          bus_we,
    output logic          bus_data,
    output logic          pc_we,
    output logic          pc_target,
    output logic          ir_we,
    output logic          ab_we,
    output logic          aluout_we,
    output logic          mdr_we,
    output logic          rf_we
);

    rv_pkg::state_t state;
    rv_pkg::state_t next_state;
    logic           run;       // Set at the first edge out of reset
    logic           bus_done;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= rv_pkg::s_fetch;
            run   <= 1'b0;
        end else begin
            state <= next_state;
            run   <= 1'b1;
        end
    end

    // Bus is held until the slave acks
    assign bus_cyc  = run && (state == rv_pkg::s_fetch || state == rv_pkg::s_memory);
    assign bus_done = bus_cyc && wb_ack;

    always_comb begin
        next_state = state;
        bus_we     = 1'b0;
        bus_data   = 1'b0;
        pc_we      = 1'b0;
        pc_target  = 1'b0;
        ir_we      = 1'b0;
        ab_we      = 1'b0;
        aluout_we  = 1'b0;
        mdr_we     = 1'b0;
        rf_we      = 1'b0;
        case (state)
            rv_pkg::s_fetch: begin
                if (bus_done) begin
                    ir_we      = 1'b1;
                    pc_we      = 1'b1;  // PC + 4
                    next_state = rv_pkg::s_decode;
                end
            end
            rv_pkg::s_decode: begin
                ab_we      = 1'b1;
                next_state = rv_pkg::s_execute;
            end
            rv_pkg::s_execute: begin
                aluout_we = 1'b1;
                if (ctrl.jump || (ctrl.branch && branch_taken)) begin
                    pc_we     = 1'b1;
                    pc_target = 1'b1;
                end
                if (ctrl.mem_read || ctrl.mem_write)
                    next_state = rv_pkg::s_memory;
                else if (ctrl.reg_write)
                    next_state = rv_pkg::s_writeback;
                else
                    next_state = rv_pkg::s_fetch;  // Branches and unknown opcodes
            end
            rv_pkg::s_memory: begin
                bus_data = 1'b1;
                bus_we   = ctrl.mem_write;
                if (bus_done) begin
                    mdr_we     = ctrl.mem_read;
                    next_state = ctrl.mem_read ? rv_pkg::s_writeback : rv_pkg::s_fetch;
                end
            end
            rv_pkg::s_writeback: begin
                rf_we      = ctrl.reg_write;
                next_state = rv_pkg::s_fetch;
            end
            default: next_state = rv_pkg::s_fetch;
        endcase
    end

endmodule

// File: design/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                    clk,
    input  logic                    reset,
    output rv_pkg::wb_req_t         wb_req,
    input  logic                    wb_ack,
    input  logic [rv_pkg::xlen-1:0] wb_dat_r
);

    logic [rv_pkg::xlen-1:0] pc, pc_prev, ir, a, b, aluout, mdr;
    logic [rv_pkg::xlen-1:0] imm, rd1, rd2, alu_a, alu_b, alu_result, wb_data;
    rv_pkg::ctrl_t           ctrl;
    logic                    branch_taken;
    logic                    bus_cyc, bus_we, bus_data;
    logic                    pc_we, pc_target, ir_we, ab_we, aluout_we, mdr_we, rf_we;

    rv_decoder u_decoder (.instr(ir), .ctrl(ctrl), .imm(imm));

    rv_regfile u_regfile (
        .clk(clk), .reset(reset),
        .rs1(ir[19:15]), .rs2(ir[24:20]), .rd(ir[11:7]),
        .we(rf_we), .wd(wb_data), .rd1(rd1), .rd2(rd2)
    );

    assign alu_a = ctrl.lui ? '0 : a;
    assign alu_b = ctrl.alu_src_imm ? imm : b;

    rv_alu u_alu (
        .op(ctrl.alu_op), .funct3(ir[14:12]), .a(alu_a), .b(alu_b),
        .result(alu_result), .branch_taken(branch_taken)
    );

    rv_control_fsm u_fsm (
        .clk(clk), .reset(reset), .ctrl(ctrl),
        .branch_taken(branch_taken), .wb_ack(wb_ack),
        .bus_cyc(bus_cyc), .bus_we(bus_we), .bus_data(bus_data),
        .pc_we(pc_we), .pc_target(pc_target), .ir_we(ir_we), .ab_we(ab_we),
        .aluout_we(aluout_we), .mdr_we(mdr_we), .rf_we(rf_we)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc      <= '0;
            pc_prev <= '0;
            ir      <= '0;
            a       <= '0;
            b       <= '0;
            aluout  <= '0;
            mdr     <= '0;
        end else begin
            if (pc_we)
                pc <= pc_target ? pc_prev + imm : pc + 32'd4;  // Target is relative to IR's PC
            if (ir_we) begin
                ir      <= wb_dat_r;
                pc_prev <= pc;
            end
            if (ab_we) begin
                a <= rd1;
                b <= rd2;
            end
            if (aluout_we)
                aluout <= alu_result;
            if (mdr_we)
                mdr <= wb_dat_r;
        end
    end

    // Link value for JAL, PC already holds the target here
    always_comb begin
        if (ctrl.jump)
            wb_data = pc_prev + 32'd4;
        else if (ctrl.mem_to_reg)
            wb_data = mdr;
        else
            wb_data = aluout;
    end

    assign wb_req = '{cyc: bus_cyc, stb: bus_cyc, we: bus_we,
                      adr: bus_data ? aluout : pc, dat_w: b};

endmodule

// File: tests/rv_core_assert.sv
`timescale 1ns/1ps

module rv_core_assert (
    input logic            clk,
    input logic            reset,
    input rv_pkg::wb_req_t wb_req,
    input logic            wb_ack
);

    // Slot k lives at 0x200 + 4k, operands x1 = 6 and x2 = -19
    localparam logic [31:0] expected [16] = '{
        32'hFFFF_FFF3,  // add
        32'hFFFF_FFE7,  // sub
        32'h0000_0004,  // and
        32'hFFFF_FFEF,  // or
        32'hFFFF_FFEB,  // xor
        32'hFFFF_FB40,  // sll by 6
        32'h03FF_FFFF,  // srl by 6
        32'hFFFF_FFFF,  // sra by 6
        32'h0000_0001,  // slt
        32'h0000_0000,  // sltu, negative operand is large
        32'hFFFF_FC05,  // addi -1000
        32'h1234_5000,  // lui
        32'h1234_5001,  // Loaded word plus one
        32'h0000_0006,  // Not-taken branch count
        32'h0000_00E4,  // JAL at 0xE0
        32'h0000_0000   // x0 after a write attempt
    };

    int          fail_count = 0;
    logic [15:0] written;
    logic        seen_req;
    logic        write_ack;
    logic        slot_hit;
    logic [3:0]  slot;

    assign write_ack = wb_req.cyc && wb_req.stb && wb_req.we && wb_ack;
    assign slot_hit  = wb_req.adr[31:6] == 26'h8;
    assign slot      = wb_req.adr[5:2];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            written  <= '0;
            seen_req <= 1'b0;
        end else begin
            if (wb_req.cyc)
                seen_req <= 1'b1;
            if (write_ack && slot_hit)
                written[slot] <= 1'b1;
        end
    end

    idle_in_reset: assert property (@(posedge clk) reset |-> !wb_req.cyc)
        else begin
            $error("Error wb_req.cyc during reset: %h", wb_req.cyc);
            fail_count++;
        end

    first_fetch: assert property (@(posedge clk) disable iff (reset)
        (wb_req.cyc && !seen_req) |-> (wb_req.adr == '0 && !wb_req.we))
        else begin
            $error("Error first request wb_req.adr %h, wb_req.we %h", wb_req.adr, wb_req.we);
            fail_count++;
        end

    hold_until_ack: assert property (@(posedge clk) disable iff (reset)
        (wb_req.stb && !wb_ack) |=> $stable(wb_req))
        else begin
            $error("The request changed before ack, address now %h", wb_req.adr);
            fail_count++;
        end

    stb_framed: assert property (@(posedge clk) disable iff (reset)
        wb_req.stb |-> (wb_req.cyc && wb_req.adr[1:0] == 2'b00))
        else begin
            $error("Strobe without cycle or unaligned address %h", wb_req.adr);
            fail_count++;
        end

    slot_value: assert property (@(posedge clk) disable iff (reset)
        (write_ack && slot_hit) |-> wb_req.dat_w == expected[slot])
        else begin
            $error("Error wb_req.dat_w slot %0d: got %h, expected %h",
                   slot, wb_req.dat_w, expected[slot]);
            fail_count++;
        end

    no_poison: assert property (@(posedge clk) disable iff (reset)
        (wb_req.stb && wb_req.we) |-> wb_req.adr != 32'h3F8)
        else begin
            $error("A wrong-path store reached the poison address");
            fail_count++;
        end

    all_slots: assert property (@(posedge clk) disable iff (reset)
        (write_ack && wb_req.adr == 32'h3FC) |-> &written)
        else begin
            $error("Done was written with result slots missing, mask %h", written);
            fail_count++;
        end

endmodule

bind rv_core rv_core_assert u_check (
    .clk(clk), .reset(reset), .wb_req(wb_req), .wb_ack(wb_ack)
);

// File: tests/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

    localparam int max_cycles  = 3000;   // ~60 instructions at up to 12 cycles, plus margin
    localparam int poison_addr = 'h3F8;  // Only wrong-path stores target this word

    // R-type function codes in result slot order 0 to 9
    localparam int alu_f7 [10] = '{0, 'h20, 0, 0, 0, 0, 0, 'h20, 0, 0};
    localparam int alu_f3 [10] = '{0, 0, 7, 6, 4, 1, 5, 5, 2, 3};

    logic            clk      = 1'b0;
    logic            reset    = 1'b1;
    logic            wb_ack   = 1'b0;
    logic [31:0]     wb_dat_r = '0;
    rv_pkg::wb_req_t wb_req;

    logic [31:0] mem [1024];
    logic [31:0] lcg_state = 32'h8428;
    logic        pending   = 1'b0;   // Current request already has its wait count
    logic        done      = 1'b0;
    int          wait_cnt  = 0;
    int          pc_word   = 0;
    int          cycles    = 0;

    rv_core uut (
        .clk(clk), .reset(reset), .wb_req(wb_req),
        .wb_ack(wb_ack), .wb_dat_r(wb_dat_r)
    );

    always #10 clk = ~clk;

    // Instruction encoders, RV32I base formats
    function automatic logic [31:0] alu_rr(input int f7, f3, rd, rs1, rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] imm_op(input int op, f3, rd, rs1, imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] store_word(input int rs2, rs1, imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_to(input int f3, rs1, rs2, off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jump_link(input int rd, off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] upper_imm(input int rd, imm);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    // LCG step, returns 0 to 2 wait states
    function automatic int wait_states();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[31:16] % 16'd3);
    endfunction

    task automatic emit(input logic [31:0] instr);
        mem[pc_word] = instr;
        pc_word++;
    endtask

    // Taken branch over a poison store, then a not-taken one over a counter bump
    task automatic branch_pair(input int f3, t1, t2, n1, n2);
        emit(branch_to(f3, t1, t2, 8));
        emit(store_word(31, 0, poison_addr));
        emit(branch_to(f3, n1, n2, 8));
        emit(imm_op('h13, 0, 20, 20, 1));
    endtask

    task automatic load_program();
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'hFEED0000 ^ i;
        end
        emit(imm_op('h13, 0, 1, 0, 6));        // x1 = 6
        emit(imm_op('h13, 0, 2, 0, -19));      // x2 = -19
        emit(imm_op('h13, 0, 31, 0, 'h5A5));   // Poison value
        for (int k = 0; k < 10; k++) begin
            emit(alu_rr(alu_f7[k], alu_f3[k], 4, 2, 1));
            emit(store_word(4, 0, 'h200 + 4 * k));
        end
        emit(imm_op('h13, 0, 4, 2, -1000));
        emit(store_word(4, 0, 'h228));
        emit(upper_imm(4, 'h12345));
        emit(store_word(4, 0, 'h22C));
        // Word round trip through data memory
        emit(store_word(4, 0, 'h100));
        emit(imm_op('h03, 2, 6, 0, 'h100));
        emit(imm_op('h13, 0, 6, 6, 1));
        emit(store_word(6, 0, 'h230));
        branch_pair(0, 1, 1, 1, 2);  // beq
        branch_pair(1, 1, 2, 1, 1);  // bne
        branch_pair(4, 2, 1, 1, 2);  // blt
        branch_pair(5, 1, 2, 2, 1);  // bge
        branch_pair(6, 1, 2, 2, 1);  // bltu
        branch_pair(7, 2, 1, 1, 2);  // bgeu
        emit(store_word(20, 0, 'h234));
        emit(jump_link(5, 8));                 // Sits at 0xE0
        emit(store_word(31, 0, poison_addr));
        emit(store_word(5, 0, 'h238));
        emit(imm_op('h13, 0, 0, 0, 5));        // Write to x0
        emit(store_word(0, 0, 'h23C));
        emit(imm_op('h13, 0, 7, 0, 1));
        emit(store_word(7, 0, 'h3FC));
        emit(jump_link(0, 0));                 // Spin here
    endtask

    // Wishbone slave with random wait states
    always @(posedge clk) begin
        #1;
        if (wb_ack || !wb_req.stb) begin
            wb_ack  = 1'b0;
            pending = 1'b0;
        end
        if (!reset && wb_req.cyc && wb_req.stb) begin
            if (!pending) begin
                pending  = 1'b1;
                wait_cnt = wait_states();
            end
            if (wait_cnt == 0) begin
                if (wb_req.we) begin
                    mem[wb_req.adr[11:2]] = wb_req.dat_w;
                    if (wb_req.adr == 32'h3FC && wb_req.dat_w == 32'd1)
                        done = 1'b1;
                end
                wb_dat_r = mem[wb_req.adr[11:2]];
                wb_ack   = 1'b1;
            end else begin
                wait_cnt--;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Some tests failed");
            $fatal(1, "Timeout: the program never wrote the done word in %0d cycles", max_cycles);
        end
    end

    always @(negedge clk) begin
        if (uut.u_check.fail_count != 0) begin
            $display("Some tests failed");
            $fatal(1, "The bus checker saw a failing assertion");
        end
    end

    initial begin
        load_program();
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        wait (done);
        repeat (2) @(negedge clk);  // Let the done edge assertions settle
        if (uut.u_check.fail_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "%0d checker failures", uut.u_check.fail_count);
        end
    end

endmodule

// File: sim.f
design/rv_pkg.sv
design/rv_alu.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_control_fsm.sv
design/rv_core.sv
tests/rv_core_assert.sv
tests/rv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert
RUN_ARGS  ?= +verilator+error+limit+100

SRCS := $(shell grep -v '^+' sim.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) sim.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sim.f

run: $(BIN)
	$(BIN) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)
